/* src/sampler_pkg.sv */
package sampler_pkg;

    localparam int DATA_SIZE    = 8;
    localparam int BUFFER_DEPTH = 64;
    localparam int ADDR_SIZE    = 6;

    typedef logic [DATA_SIZE-1:0] sample_t;
    typedef logic [ADDR_SIZE-1:0] addr_t;

    // Top two bits of a command byte.
    typedef enum logic [1:0] {
        CMD_SET_LEN = 2'b00,
        CMD_ARM     = 2'b01,
        CMD_DISARM  = 2'b10,
        CMD_DUMP    = 2'b11
    } cmd_op_t;

    typedef enum logic [1:0] {
        S_IDLE    = 2'b00,
        S_ARMED   = 2'b01,
        S_CAPTURE = 2'b10,
        S_SEND    = 2'b11
    } sampler_state_t;

endpackage

/* src/uart_pkg.sv */
package uart_pkg;

    localparam int CLKS_PER_BIT = 16;
    localparam int CLK_CNT_SIZE = $clog2(CLKS_PER_BIT);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

endpackage

/* src/sample_buffer.sv */
`timescale 1ns/100ps

module sample_buffer (
    input  logic                 i_clock,
    input  logic                 i_we,
    input  sampler_pkg::addr_t   i_waddr,
    input  sampler_pkg::sample_t i_wdata,
    input  sampler_pkg::addr_t   i_raddr,
    output sampler_pkg::sample_t o_rdata
);

    sampler_pkg::sample_t mem [sampler_pkg::BUFFER_DEPTH];

    always_ff @(posedge i_clock) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // Registered read with data one cycle after the address.
    always_ff @(posedge i_clock) begin
        o_rdata <= mem[i_raddr];
    end

endmodule

/* src/sampler.sv */
`timescale 1ns/100ps

module sampler (
    input  logic                 i_clock,
    input  logic                 i_rst,
    input  sampler_pkg::sample_t i_data,
    input  logic                 i_adc_init,
    input  logic                 i_gate,
    input  logic                 i_sample,
    input  sampler_pkg::sample_t i_rx_data,
    input  logic                 i_rx_valid,
    input  logic                 i_tx_ready,
    output sampler_pkg::sample_t o_tx_data,
    output logic                 o_tx_valid,
    output logic                 o_we,
    output sampler_pkg::addr_t   o_waddr,
    output sampler_pkg::sample_t o_wdata,
    output sampler_pkg::addr_t   o_raddr,
    input  sampler_pkg::sample_t i_rdata,
    output logic                 o_busy
);

    sampler_pkg::sampler_state_t state;
    sampler_pkg::cmd_op_t        cmd_op;
    sampler_pkg::addr_t          length;
    sampler_pkg::addr_t          last_addr;
    logic                        armed;
    logic                        have_capture;
    logic                        gate_q;
    logic                        idle;
    logic                        gate_hit;
    logic                        trigger;
    logic [1:0]                  send_step;

    // A stored length of zero wraps to the last buffer entry.
    assign last_addr = length - 1'b1;

    assign cmd_op   = sampler_pkg::cmd_op_t'(i_rx_data[7:6]);
    assign idle     = (state == sampler_pkg::S_IDLE) || (state == sampler_pkg::S_ARMED);
    assign gate_hit = (state == sampler_pkg::S_ARMED) && i_gate && !gate_q;
    assign trigger  = idle && i_adc_init && (i_sample || gate_hit);

    assign o_busy  = !idle;
    assign o_we    = (state == sampler_pkg::S_CAPTURE);
    assign o_wdata = i_data;

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            gate_q <= 1'b0;
        end else begin
            gate_q <= i_gate;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            state        <= sampler_pkg::S_IDLE;
            length       <= '0;
            armed        <= 1'b0;
            have_capture <= 1'b0;
            o_waddr      <= '0;
            o_raddr      <= '0;
            send_step    <= '0;
            o_tx_valid   <= 1'b0;
        end else begin
            case (state)
                sampler_pkg::S_IDLE, sampler_pkg::S_ARMED: begin
                    if (trigger) begin
                        state        <= sampler_pkg::S_CAPTURE;
                        o_waddr      <= '0;
                        have_capture <= 1'b1;
                        // A gate capture uses up the arming.
                        armed        <= armed && !gate_hit;
                    end else if (i_rx_valid) begin
                        case (cmd_op)
                            sampler_pkg::CMD_SET_LEN: begin
                                length <= i_rx_data[sampler_pkg::ADDR_SIZE-1:0];
                            end
                            sampler_pkg::CMD_ARM: begin
                                armed <= 1'b1;
                                state <= sampler_pkg::S_ARMED;
                            end
                            sampler_pkg::CMD_DISARM: begin
                                armed <= 1'b0;
                                state <= sampler_pkg::S_IDLE;
                            end
                            sampler_pkg::CMD_DUMP: begin
                                if (have_capture) begin
                                    state     <= sampler_pkg::S_SEND;
                                    o_raddr   <= '0;
                                    send_step <= '0;
                                end
                            end
                        endcase
                    end
                end
                sampler_pkg::S_CAPTURE: begin
                    if (o_waddr == last_addr) begin
                        state     <= sampler_pkg::S_SEND;
                        o_raddr   <= '0;
                        send_step <= '0;
                    end else begin
                        o_waddr <= o_waddr + 1'b1;
                    end
                end
                sampler_pkg::S_SEND: begin
                    // Step 0 presents the address, step 1 sees the data, step 2 offers it.
                    case (send_step)
                        2'd0: begin
                            send_step <= 2'd1;
                        end
                        2'd1: begin
                            o_tx_valid <= 1'b1;
                            send_step  <= 2'd2;
                        end
                        default: begin
                            if (i_tx_ready) begin
                                o_tx_valid <= 1'b0;
                                send_step  <= 2'd0;
                                if (o_raddr == last_addr) begin
                                    state <= armed ? sampler_pkg::S_ARMED : sampler_pkg::S_IDLE;
                                end else begin
                                    o_raddr <= o_raddr + 1'b1;
                                end
                            end
                        end
                    endcase
                end
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (state == sampler_pkg::S_SEND && send_step == 2'd1) begin
            o_tx_data <= i_rdata;
        end
    end

endmodule

/* src/uart_rx.sv */
`timescale 1ns/100ps

module uart_rx (
    input  logic                 i_clock,
    input  logic                 i_rst,
    input  logic                 i_rxd,
    output sampler_pkg::sample_t o_rx_data,
    output logic                 o_rx_valid
);

    uart_pkg::rx_state_t                          state;
    logic                                         rx_meta;
    logic                                         rx_sync;
    logic [uart_pkg::CLK_CNT_SIZE-1:0]            clk_cnt;
    logic [$clog2(sampler_pkg::DATA_SIZE)-1:0]    bit_cnt;
    logic                                         half_end;
    logic                                         bit_end;

    assign half_end = (clk_cnt == uart_pkg::CLKS_PER_BIT / 2 - 1);
    assign bit_end  = (clk_cnt == uart_pkg::CLKS_PER_BIT - 1);

    // Two flop synchroniser on a line that idles high.
    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= i_rxd;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            state      <= uart_pkg::RX_IDLE;
            clk_cnt    <= '0;
            bit_cnt    <= '0;
            o_rx_valid <= 1'b0;
        end else begin
            o_rx_valid <= 1'b0;
            case (state)
                uart_pkg::RX_IDLE: begin
                    clk_cnt <= '0;
                    if (!rx_sync) begin
                        state <= uart_pkg::RX_START;
                    end
                end
                uart_pkg::RX_START: begin
                    if (half_end) begin
                        clk_cnt <= '0;
                        bit_cnt <= '0;
                        // Glitch check at the middle of the start bit.
                        state   <= rx_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                uart_pkg::RX_DATA: begin
                    if (bit_end) begin
                        clk_cnt <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == sampler_pkg::DATA_SIZE - 1) begin
                            state <= uart_pkg::RX_STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                uart_pkg::RX_STOP: begin
                    if (bit_end) begin
                        clk_cnt    <= '0;
                        o_rx_valid <= rx_sync;
                        state      <= uart_pkg::RX_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // LSB arrives first.
    always_ff @(posedge i_clock) begin
        if (state == uart_pkg::RX_DATA && bit_end) begin
            o_rx_data <= {rx_sync, o_rx_data[sampler_pkg::DATA_SIZE-1:1]};
        end
    end

endmodule

/* src/uart_tx.sv */
`timescale 1ns/100ps

module uart_tx (
    input  logic                 i_clock,
    input  logic                 i_rst,
    input  sampler_pkg::sample_t i_data,
    input  logic                 i_valid,
    output logic                 o_ready,
    output logic                 o_txd
);

    uart_pkg::tx_state_t                          state;
    sampler_pkg::sample_t                         data_q;
    logic [uart_pkg::CLK_CNT_SIZE-1:0]            clk_cnt;
    logic [$clog2(sampler_pkg::DATA_SIZE)-1:0]    bit_cnt;
    logic                                         bit_end;

    assign o_ready = (state == uart_pkg::TX_IDLE);
    assign bit_end = (clk_cnt == uart_pkg::CLKS_PER_BIT - 1);

    always_ff @(posedge i_clock) begin
        if (o_ready && i_valid) begin
            data_q <= i_data;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            state   <= uart_pkg::TX_IDLE;
            clk_cnt <= '0;
            bit_cnt <= '0;
            o_txd   <= 1'b1;
        end else begin
            if (state == uart_pkg::TX_IDLE || bit_end) begin
                clk_cnt <= '0;
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
            case (state)
                uart_pkg::TX_IDLE: begin
                    if (i_valid) begin
                        o_txd <= 1'b0;
                        state <= uart_pkg::TX_START;
                    end
                end
                uart_pkg::TX_START: begin
                    if (bit_end) begin
                        o_txd   <= data_q[0];
                        bit_cnt <= '0;
                        state   <= uart_pkg::TX_DATA;
                    end
                end
                uart_pkg::TX_DATA: begin
                    if (bit_end) begin
                        if (bit_cnt == sampler_pkg::DATA_SIZE - 1) begin
                            o_txd <= 1'b1;
                            state <= uart_pkg::TX_STOP;
                        end else begin
                            o_txd   <= data_q[bit_cnt + 1'b1];
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                uart_pkg::TX_STOP: begin
                    if (bit_end) begin
                        state <= uart_pkg::TX_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

/* src/adc_capture_top.sv */
`timescale 1ns/100ps

module adc_capture_top (
    input  logic                 i_clock,
    input  logic                 i_rst,
    input  sampler_pkg::sample_t i_data,
    input  logic                 i_adc_init,
    input  logic                 i_gate,
    input  logic                 i_sample,
    input  logic                 i_rxd,
    output logic                 o_txd,
    output logic                 o_busy
);

    sampler_pkg::sample_t rx_data;
    logic                 rx_valid;
    sampler_pkg::sample_t tx_data;
    logic                 tx_valid;
    logic                 tx_ready;
    logic                 we;
    sampler_pkg::addr_t   waddr;
    sampler_pkg::sample_t wdata;
    sampler_pkg::addr_t   raddr;
    sampler_pkg::sample_t rdata;

    uart_rx u_uart_rx (
        .i_clock    (i_clock),
        .i_rst      (i_rst),
        .i_rxd      (i_rxd),
        .o_rx_data  (rx_data),
        .o_rx_valid (rx_valid)
    );

    sampler u_sampler (
        .i_clock    (i_clock),
        .i_rst      (i_rst),
        .i_data     (i_data),
        .i_adc_init (i_adc_init),
        .i_gate     (i_gate),
        .i_sample   (i_sample),
        .i_rx_data  (rx_data),
        .i_rx_valid (rx_valid),
        .i_tx_ready (tx_ready),
        .o_tx_data  (tx_data),
        .o_tx_valid (tx_valid),
        .o_we       (we),
        .o_waddr    (waddr),
        .o_wdata    (wdata),
        .o_raddr    (raddr),
        .i_rdata    (rdata),
        .o_busy     (o_busy)
    );

    sample_buffer u_sample_buffer (
        .i_clock    (i_clock),
        .i_we       (we),
        .i_waddr    (waddr),
        .i_wdata    (wdata),
        .i_raddr    (raddr),
        .o_rdata    (rdata)
    );

    uart_tx u_uart_tx (
        .i_clock    (i_clock),
        .i_rst      (i_rst),
        .i_data     (tx_data),
        .i_valid    (tx_valid),
        .o_ready    (tx_ready),
        .o_txd      (o_txd)
    );

endmodule

/* bench/sampler_assertions.sv */
`timescale 1ns/100ps

module sampler_assertions (
    input logic                        i_clock,
    input logic                        i_rst,
    input logic                        i_adc_init,
    input logic                        i_tx_ready,
    input logic                        i_tx_valid,
    input sampler_pkg::sample_t        i_tx_data,
    input logic                        i_we,
    input sampler_pkg::addr_t          i_waddr,
    input sampler_pkg::sampler_state_t i_state
);

    int error_count = 0;

    // A byte on offer is held until the transmitter takes it.
    tx_hold: assert property (@(posedge i_clock) disable iff (i_rst)
        i_tx_valid && !i_tx_ready |=> i_tx_valid && $stable(i_tx_data))
    else begin
        error_count++;
        $error("o_tx_valid dropped or o_tx_data changed before the handshake");
    end

    // Writes start at address zero straight from idle and then run on consecutive addresses.
    write_burst: assert property (@(posedge i_clock) disable iff (i_rst)
        i_we |->
            (i_waddr == '0 &&
             $past(i_state == sampler_pkg::S_IDLE || i_state == sampler_pkg::S_ARMED)) ||
            ($past(i_we) && i_waddr == $past(i_waddr) + 1'b1))
    else begin
        error_count++;
        $error("o_we high outside a capture burst");
    end

    // No capture may start from idle while the ADC is not ready.
    no_trigger_uninit: assert property (@(posedge i_clock) disable iff (i_rst)
        !i_adc_init && (i_state == sampler_pkg::S_IDLE || i_state == sampler_pkg::S_ARMED)
        |=> i_state != sampler_pkg::S_CAPTURE)
    else begin
        error_count++;
        $error("capture started while i_adc_init was low");
    end

endmodule

bind sampler sampler_assertions u_sampler_assertions (
    .i_clock    (i_clock),
    .i_rst      (i_rst),
    .i_adc_init (i_adc_init),
    .i_tx_ready (i_tx_ready),
    .i_tx_valid (o_tx_valid),
    .i_tx_data  (o_tx_data),
    .i_we       (o_we),
    .i_waddr    (o_waddr),
    .i_state    (state)
);

/* bench/adc_capture_tb.sv */
`timescale 1ns/100ps

module adc_capture_tb;

    localparam int BIT_CLKS  = uart_pkg::CLKS_PER_BIT;
    localparam int BYTE_CLKS = 10 * BIT_CLKS;
    // Serial bytes over all tests, commands and quiet windows included.
    localparam int TEST_BYTES = 400;
    localparam int MAX_CYCLES = TEST_BYTES * BYTE_CLKS + 20000;

    logic                 i_clock;
    logic                 i_rst;
    sampler_pkg::sample_t i_data;
    logic                 i_adc_init;
    logic                 i_gate;
    logic                 i_sample;
    logic                 i_rxd;
    logic                 o_txd;
    logic                 o_busy;

    sampler_pkg::sample_t rx_bytes[$];
    sampler_pkg::sample_t expected[$];
    int                   errors = 0;
    int                   cycle_count = 0;
    logic [7:0]           lfsr_state = 8'd42;

    adc_capture_top i_dut (
        .i_clock    (i_clock),
        .i_rst      (i_rst),
        .i_data     (i_data),
        .i_adc_init (i_adc_init),
        .i_gate     (i_gate),
        .i_sample   (i_sample),
        .i_rxd      (i_rxd),
        .o_txd      (o_txd),
        .o_busy     (o_busy)
    );

    always #4 i_clock = ~i_clock;

    // Free-running ADC data makes every cycle's sample known.
    always @(posedge i_clock) begin
        i_data <= i_data + 1'b1;
    end

    always @(posedge i_clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles.", MAX_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // Serial monitor sampling o_txd in the middle of each bit.
    initial begin
        sampler_pkg::sample_t shift;
        forever begin
            @(negedge i_clock);
            if (o_txd === 1'b0) begin
                repeat (BIT_CLKS / 2) @(negedge i_clock);
                if (o_txd === 1'b0) begin
                    for (int b = 0; b < sampler_pkg::DATA_SIZE; b++) begin
                        repeat (BIT_CLKS) @(negedge i_clock);
                        shift[b] = o_txd;
                    end
                    repeat (BIT_CLKS) @(negedge i_clock);
                    if (o_txd === 1'b1) begin
                        rx_bytes.push_back(shift);
                    end else begin
                        $display("At %0t a byte on o_txd had no stop bit.", $time);
                        errors++;
                    end
                end
            end
        end
    end

    // 8-bit Fibonacci LFSR with taps 8 6 5 4.
    function automatic logic [7:0] lfsr_step(input logic [7:0] state);
        return {state[6:0], state[7] ^ state[5] ^ state[4] ^ state[3]};
    endfunction

    task automatic check_sample(input string name, input sampler_pkg::sample_t exp,
                                input sampler_pkg::sample_t act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %02h actual %02h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("ERR %0t %s expected %0d actual %0d", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic send_byte(input sampler_pkg::sample_t value);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0};
        for (int b = 0; b < 10; b++) begin
            @(posedge i_clock);
            i_rxd <= frame[b];
            repeat (BIT_CLKS - 1) @(posedge i_clock);
        end
        // Receiver and sampler take the byte near the end of the stop bit.
        repeat (8) @(posedge i_clock);
    endtask

    task automatic pulse_sample(output sampler_pkg::sample_t first);
        @(posedge i_clock);
        i_sample <= 1'b1;
        @(posedge i_clock);
        i_sample <= 1'b0;
        // First stored word is the one present after the trigger edge.
        @(negedge i_clock);
        first = i_data;
    endtask

    task automatic raise_gate(output sampler_pkg::sample_t first);
        @(posedge i_clock);
        i_gate <= 1'b1;
        @(posedge i_clock);
        @(negedge i_clock);
        first = i_data;
    endtask

    task automatic finish_readout();
        @(negedge i_clock);
        check_level("o_busy", 1'b1, o_busy);
        while (o_busy) begin
            @(negedge i_clock);
        end
        // The last byte is still on the line after the final handshake.
        repeat (BYTE_CLKS + BIT_CLKS) @(negedge i_clock);
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge i_clock);
            check_level("o_busy", 1'b0, o_busy);
            check_level("o_txd", 1'b1, o_txd);
        end
        check_count("serial byte count", 0, rx_bytes.size());
        rx_bytes.delete();
    endtask

    task automatic compare_stream(input string what);
        check_count({what, " byte count"}, expected.size(), rx_bytes.size());
        for (int i = 0; i < expected.size() && i < rx_bytes.size(); i++) begin
            check_sample($sformatf("%s byte %0d", what, i), expected[i], rx_bytes[i]);
        end
        rx_bytes.delete();
    endtask

    task automatic capture_and_check(input sampler_pkg::addr_t len_code);
        sampler_pkg::sample_t first;
        int                   count;
        count = (len_code == 0) ? sampler_pkg::BUFFER_DEPTH : int'(len_code);
        send_byte({sampler_pkg::CMD_SET_LEN, len_code});
        pulse_sample(first);
        finish_readout();
        expected.delete();
        for (int i = 0; i < count; i++) begin
            expected.push_back(sampler_pkg::sample_t'(first + i));
        end
        compare_stream($sformatf("capture of %0d", count));
    endtask

    task automatic test_idle();
        expect_quiet(100);
        @(posedge i_clock);
        i_sample <= 1'b1;
        @(posedge i_clock);
        i_sample <= 1'b0;
        expect_quiet(2 * BYTE_CLKS);
    endtask

    task automatic test_gate();
        sampler_pkg::sample_t first;
        send_byte({sampler_pkg::CMD_SET_LEN, 6'd12});
        send_byte({sampler_pkg::CMD_ARM, 6'd0});
        raise_gate(first);
        finish_readout();
        expected.delete();
        for (int i = 0; i < 12; i++) begin
            expected.push_back(sampler_pkg::sample_t'(first + i));
        end
        compare_stream("gate capture");
        @(posedge i_clock);
        i_gate <= 1'b0;
        repeat (4) @(posedge i_clock);
        // Arming was used up by the first capture.
        i_gate <= 1'b1;
        expect_quiet(2 * BYTE_CLKS);
        @(posedge i_clock);
        i_gate <= 1'b0;
    endtask

    task automatic test_lengths();
        sampler_pkg::addr_t len_code;
        for (int run = 0; run < 4; run++) begin
            len_code = '0;
            for (int b = 0; b < sampler_pkg::ADDR_SIZE; b++) begin
                lfsr_state = lfsr_step(lfsr_state);
                len_code[b] = lfsr_state[0];
            end
            capture_and_check(len_code);
        end
        capture_and_check('0);
    endtask

    task automatic test_dump();
        sampler_pkg::sample_t first;
        capture_and_check(6'd10);
        send_byte({sampler_pkg::CMD_DUMP, 6'd0});
        finish_readout();
        compare_stream("dump");
        send_byte({sampler_pkg::CMD_ARM, 6'd0});
        send_byte({sampler_pkg::CMD_DISARM, 6'd0});
        raise_gate(first);
        expect_quiet(2 * BYTE_CLKS);
        @(posedge i_clock);
        i_gate <= 1'b0;
    endtask

    initial begin
        int assert_errors;
        i_clock    = 1'b0;
        i_rst      = 1'b1;
        i_data     = '0;
        i_adc_init = 1'b0;
        i_gate     = 1'b0;
        i_sample   = 1'b0;
        i_rxd      = 1'b1;
        repeat (5) @(posedge i_clock);
        i_rst <= 1'b0;

        test_idle();
        @(posedge i_clock);
        i_adc_init <= 1'b1;
        capture_and_check(6'd8);
        test_gate();
        test_lengths();
        test_dump();

        assert_errors = i_dut.u_sampler.u_sampler_assertions.error_count;
        $display("Check errors: %0d, assertion errors: %0d", errors, assert_errors);
        if (errors == 0 && assert_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
src/sampler_pkg.sv
src/uart_pkg.sv
src/sample_buffer.sv
src/sampler.sv
src/uart_rx.sv
src/uart_tx.sv
src/adc_capture_top.sv
bench/sampler_assertions.sv
bench/adc_capture_tb.sv

/* Bender.yml */
package:
  name: adc_capture

sources:
  - src/sampler_pkg.sv
  - src/uart_pkg.sv
  - src/sample_buffer.sv
  - src/sampler.sv
  - src/uart_rx.sv
  - src/uart_tx.sv
  - src/adc_capture_top.sv
  - target: test
    files:
      - bench/sampler_assertions.sv
      - bench/adc_capture_tb.sv
